// File: Makefile
# Verilator build and run for the loader testbench

SRCS := $(shell grep -v '^+' compile.f) common/loader_cfg.svh

obj_dir/Vtb_top: compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f compile.f

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top | tee sim.log
	@if grep -q "Test failed" sim.log; then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: common/loader_cfg.svh
// Loader configuration constants
// Widths, load addresses, host file indices and write queue sizing

`ifndef LOADER_CFG_SVH
`define LOADER_CFG_SVH

// ==============================
// Memory side
// ==============================
`define LDR_ADDR_W        25
`define LDR_Q_DEPTH       16

// ==============================
// Host file indices
// ==============================
`define LDR_IDX_PRG       8'h04
`define LDR_IDX_CRT       8'h05
`define LDR_IDX_CRT_ALT   8'hC0

// ==============================
// Cartridge image layout
// ==============================
// Cartridge data lands above the 1 MB line
`define LDR_CRT_BASE      25'h100000
`define LDR_CRT_HDR_LEN   'h40
`define LDR_CRT_PKT_HDR   16
// Each chip packet starts on an 8 KB boundary
`define LDR_BANK_BITS     13

// Program injection pointer scan covers page zero
`define LDR_MEMINIT_END   'h100

`endif

// File: common/loader_pkg.sv
// Loader shared types
// Host byte, memory write, cartridge descriptor and injection range records

`include "loader_cfg.svh"

package loader_pkg;

	// One byte from the host download stream
	typedef struct packed {
		logic [7:0]             idx;
		logic [`LDR_ADDR_W-1:0] addr;
		logic [7:0]             data;
	} dl_byte_t;

	// One byte write towards emulated memory
	typedef struct packed {
		logic [`LDR_ADDR_W-1:0] addr;
		logic [7:0]             data;
	} mem_wr_t;

	// Chip packet descriptor, fields as in the packet header
	typedef struct packed {
		logic [7:0]  chip_type;
		logic [15:0] bank_num;
		logic [15:0] load_addr;
		logic [15:0] size;
	} crt_bank_t;

	// Cartridge file header fields
	typedef struct packed {
		logic [15:0] hw_id;
		logic [7:0]  exrom;
		logic [7:0]  game;
	} crt_info_t;

	// Address span of an injected program
	typedef struct packed {
		logic [15:0] start_addr;
		logic [15:0] end_addr;
	} inj_range_t;

endpackage

// File: compile.f
+incdir+common
common/loader_pkg.sv
design/loader/prg_injector.sv
design/loader/crt_parser.sv
design/loader/mem_write_arbiter.sv
design/c64_loader_top.sv
test/tb_clock.sv
test/tb_top.sv

// File: design/c64_loader_top.sv
// C64 loader top level
// Host download stream in, merged memory writes and cartridge info out

`timescale 1ns/1ns

module c64_loader_top import loader_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_n,
	input  logic       dl_wr_i,
	input  logic       dl_active_i,
	input  dl_byte_t   dl_byte_i,
	input  logic       mem_slot_i,
	output logic       mem_wr_o,
	output mem_wr_t    mem_wr_data_o,
	output logic       bank_wr_o,
	output crt_bank_t  bank_o,
	output crt_info_t  crt_info_o,
	output logic       cart_attached_o,
	output inj_range_t inj_range_o,
	output logic       inj_done_o,
	output logic       overflow_o
);

	logic    prg_wr;
	mem_wr_t prg_wr_data;
	logic    crt_wr;
	mem_wr_t crt_wr_data;

	// Both sources watch the whole stream and pick their own file indices
	prg_injector u_prg_injector (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_wr_i     (dl_wr_i),
		.dl_active_i (dl_active_i),
		.dl_byte_i   (dl_byte_i),
		.wr_o        (prg_wr),
		.wr_data_o   (prg_wr_data),
		.inj_range_o (inj_range_o),
		.inj_done_o  (inj_done_o)
	);

	crt_parser u_crt_parser (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_wr_i         (dl_wr_i),
		.dl_active_i     (dl_active_i),
		.dl_byte_i       (dl_byte_i),
		.wr_o            (crt_wr),
		.wr_data_o       (crt_wr_data),
		.bank_wr_o       (bank_wr_o),
		.bank_o          (bank_o),
		.crt_info_o      (crt_info_o),
		.cart_attached_o (cart_attached_o)
	);

	mem_write_arbiter u_mem_write_arbiter (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.prg_wr_i      (prg_wr),
		.prg_data_i    (prg_wr_data),
		.crt_wr_i      (crt_wr),
		.crt_data_i    (crt_wr_data),
		.mem_slot_i    (mem_slot_i),
		.mem_wr_o      (mem_wr_o),
		.mem_wr_data_o (mem_wr_data_o),
		.overflow_o    (overflow_o)
	);

endmodule

// File: design/loader/crt_parser.sv
// CRT parser
// Latches the cartridge file header, decodes each chip packet header into a
// bank descriptor and writes the packet data from the cartridge base upward

`timescale 1ns/1ns
`include "loader_cfg.svh"

module crt_parser import loader_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      dl_wr_i,
	input  logic      dl_active_i,
	input  dl_byte_t  dl_byte_i,
	output logic      wr_o,
	output mem_wr_t   wr_data_o,
	output logic      bank_wr_o,
	output crt_bank_t bank_o,
	output crt_info_t crt_info_o,
	output logic      cart_attached_o
);

	logic                   is_crt;
	logic                   crt_byte;
	logic                   in_pkt_area;
	logic                   pkt_start;
	logic                   active_d;
	logic                   dl_end;
	logic                   crt_seen;
	logic [`LDR_ADDR_W-1:0] load_addr;
	// Data bytes left in the current packet
	logic [31:0]            blk_len;
	// Position inside a packet header, zero outside
	logic [3:0]             hdr_cnt;

	assign is_crt      = (dl_byte_i.idx == `LDR_IDX_CRT) ||
	                     (dl_byte_i.idx == `LDR_IDX_CRT_ALT);
	assign crt_byte    = dl_wr_i && is_crt;
	assign in_pkt_area = dl_byte_i.addr >= `LDR_CRT_HDR_LEN;
	assign pkt_start   = (blk_len == '0) && (hdr_cnt == '0);
	assign dl_end      = active_d && !dl_active_i;

	// ==============================
	// Packet sequencing
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			active_d        <= 1'b0;
			crt_seen        <= 1'b0;
			cart_attached_o <= 1'b0;
			load_addr       <= `LDR_CRT_BASE;
			blk_len         <= '0;
			hdr_cnt         <= '0;
			wr_o            <= 1'b0;
			bank_wr_o       <= 1'b0;
		end else begin
			active_d  <= dl_active_i;
			wr_o      <= 1'b0;
			bank_wr_o <= 1'b0;

			if (crt_byte) begin
				crt_seen        <= 1'b1;
				cart_attached_o <= 1'b0;
				if (dl_byte_i.addr == '0) begin
					load_addr <= `LDR_CRT_BASE;
					blk_len   <= '0;
					hdr_cnt   <= '0;
				end else if (in_pkt_area) begin
					if (pkt_start) begin
						hdr_cnt <= 4'd1;
						// Round up to the next bank boundary
						if (load_addr[`LDR_BANK_BITS-1:0] != '0)
							load_addr <= {load_addr[`LDR_ADDR_W-1:`LDR_BANK_BITS] + 1'b1,
							              {`LDR_BANK_BITS{1'b0}}};
					end else if (hdr_cnt != '0) begin
						hdr_cnt <= hdr_cnt + 4'd1;
						case (hdr_cnt)
							// Packet length, big-endian
							4'd4: blk_len[31:24] <= dl_byte_i.data;
							4'd5: blk_len[23:16] <= dl_byte_i.data;
							4'd6: blk_len[15:8]  <= dl_byte_i.data;
							4'd7: blk_len[7:0]   <= dl_byte_i.data;
							// Length includes the header itself
							4'd8: blk_len <= blk_len - `LDR_CRT_PKT_HDR;
							4'd15: bank_wr_o <= 1'b1;
							default: ;
						endcase
					end else begin
						blk_len   <= blk_len - 32'd1;
						load_addr <= load_addr + 1'b1;
						wr_o      <= 1'b1;
					end
				end
			end

			if (dl_end && crt_seen) begin
				crt_seen        <= 1'b0;
				cart_attached_o <= 1'b1;
			end
		end
	end

	// ==============================
	// Header fields and write payload
	// ==============================
	always_ff @(posedge clk_sys) begin
		wr_data_o <= '{addr: load_addr, data: dl_byte_i.data};

		if (crt_byte) begin
			case (dl_byte_i.addr)
				`LDR_ADDR_W'('h16): crt_info_o.hw_id[15:8] <= dl_byte_i.data;
				`LDR_ADDR_W'('h17): crt_info_o.hw_id[7:0]  <= dl_byte_i.data;
				`LDR_ADDR_W'('h18): crt_info_o.exrom       <= dl_byte_i.data;
				`LDR_ADDR_W'('h19): crt_info_o.game        <= dl_byte_i.data;
				default: ;
			endcase

			if (in_pkt_area && hdr_cnt != '0) begin
				case (hdr_cnt)
					4'd9:  bank_o.chip_type       <= dl_byte_i.data;
					4'd10: bank_o.bank_num[15:8]  <= dl_byte_i.data;
					4'd11: bank_o.bank_num[7:0]   <= dl_byte_i.data;
					4'd12: bank_o.load_addr[15:8] <= dl_byte_i.data;
					4'd13: bank_o.load_addr[7:0]  <= dl_byte_i.data;
					4'd14: bank_o.size[15:8]      <= dl_byte_i.data;
					4'd15: bank_o.size[7:0]       <= dl_byte_i.data;
					default: ;
				endcase
			end
		end
	end

endmodule

// File: design/loader/mem_write_arbiter.sv
// Memory write arbiter
// Merges the program and cartridge write streams into one queue that
// drains one entry per memory slot, in arrival order

`timescale 1ns/1ns
`include "loader_cfg.svh"

module mem_write_arbiter import loader_pkg::*; (
	input  logic    clk_sys,
	input  logic    reset_n,
	input  logic    prg_wr_i,
	input  mem_wr_t prg_data_i,
	input  logic    crt_wr_i,
	input  mem_wr_t crt_data_i,
	input  logic    mem_slot_i,
	output logic    mem_wr_o,
	output mem_wr_t mem_wr_data_o,
	output logic    overflow_o
);

	localparam int PTR_W = $clog2(`LDR_Q_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	mem_wr_t          q_mem [`LDR_Q_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	mem_wr_t          push_data;
	logic             q_empty;
	logic             q_full;
	logic             pop;
	logic             bypass;
	logic             store;
	logic             take;

	assign push      = prg_wr_i || crt_wr_i;
	assign push_data = prg_wr_i ? prg_data_i : crt_data_i;
	assign q_empty   = count == '0;
	assign q_full    = count == CNT_W'(`LDR_Q_DEPTH);

	// An empty queue hands a same-cycle push straight to the output
	assign pop    = mem_slot_i && (!q_empty || push);
	assign bypass = pop && q_empty;
	assign store  = push && !q_full && !bypass;
	assign take   = pop && !q_empty;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			mem_wr_o   <= 1'b0;
			overflow_o <= 1'b0;
		end else begin
			mem_wr_o <= pop;
			count    <= count + CNT_W'(store) - CNT_W'(take);
			if (store)
				wr_ptr <= (wr_ptr == PTR_W'(`LDR_Q_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (take)
				rd_ptr <= (rd_ptr == PTR_W'(`LDR_Q_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Dropped write, held until reset
			if (push && q_full)
				overflow_o <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (store)
			q_mem[wr_ptr] <= push_data;
		if (pop)
			mem_wr_data_o <= bypass ? push_data : q_mem[rd_ptr];
	end

	// Only one file type downloads at a time
	a_one_source: assert property (@(posedge clk_sys) disable iff (!reset_n)
		!(prg_wr_i && crt_wr_i));

	// Slots come often enough that the queue never fills
	a_no_full_push: assert property (@(posedge clk_sys) disable iff (!reset_n)
		push |-> !q_full);

endmodule

// File: design/loader/prg_injector.sv
// PRG injector
// Takes the load address from the first two bytes, writes the payload upward
// and sets the BASIC pointers in page zero once the download ends

`timescale 1ns/1ns
`include "loader_cfg.svh"

module prg_injector import loader_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_n,
	input  logic       dl_wr_i,
	input  logic       dl_active_i,
	input  dl_byte_t   dl_byte_i,
	output logic       wr_o,
	output mem_wr_t    wr_data_o,
	output inj_range_t inj_range_o,
	output logic       inj_done_o
);

	logic        is_prg;
	logic        prg_byte;
	logic        active_d;
	logic        dl_end;
	logic        prg_seen;
	logic [15:0] load_addr;
	logic        scan_run;
	logic [8:0]  scan_addr;
	logic [8:0]  scan_next;
	logic        ptr_hit;
	logic [7:0]  ptr_val;

	assign is_prg    = dl_byte_i.idx == `LDR_IDX_PRG;
	assign prg_byte  = dl_wr_i && is_prg;
	assign dl_end    = active_d && !dl_active_i;
	assign scan_next = scan_addr + 9'd1;

	// Pointer values as a BASIC LOAD would leave them
	always_comb begin
		ptr_hit = 1'b1;
		ptr_val = 8'h00;
		case (scan_addr[7:0])
			// Start of BASIC text, reset value
			8'h2b: ptr_val = 8'h01;
			8'h2c: ptr_val = 8'h08;
			8'hac, 8'had: ptr_val = 8'h00;
			// Variables, arrays, strings and load end all point past the program
			8'h2d, 8'h2f, 8'h31, 8'hae: ptr_val = inj_range_o.end_addr[7:0];
			8'h2e, 8'h30, 8'h32, 8'haf: ptr_val = inj_range_o.end_addr[15:8];
			default: ptr_hit = 1'b0;
		endcase
	end

	// ==============================
	// Header capture, payload and scan control
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			active_d    <= 1'b0;
			prg_seen    <= 1'b0;
			load_addr   <= '0;
			inj_range_o <= '0;
			scan_run    <= 1'b0;
			scan_addr   <= '0;
			wr_o        <= 1'b0;
			inj_done_o  <= 1'b0;
		end else begin
			active_d   <= dl_active_i;
			wr_o       <= 1'b0;
			inj_done_o <= 1'b0;

			if (prg_byte) begin
				prg_seen <= 1'b1;
				if (dl_byte_i.addr == '0) begin
					load_addr[7:0]              <= dl_byte_i.data;
					inj_range_o.start_addr[7:0] <= dl_byte_i.data;
					inj_range_o.end_addr[7:0]   <= dl_byte_i.data;
				end else if (dl_byte_i.addr == `LDR_ADDR_W'(1)) begin
					load_addr[15:8]              <= dl_byte_i.data;
					inj_range_o.start_addr[15:8] <= dl_byte_i.data;
					inj_range_o.end_addr[15:8]   <= dl_byte_i.data;
				end else begin
					wr_o                 <= 1'b1;
					load_addr            <= load_addr + 16'd1;
					inj_range_o.end_addr <= inj_range_o.end_addr + 16'd1;
				end
			end

			// Download over, walk page zero
			if (dl_end && prg_seen) begin
				prg_seen  <= 1'b0;
				scan_run  <= 1'b1;
				scan_addr <= '0;
			end

			if (scan_run) begin
				wr_o      <= ptr_hit;
				scan_addr <= scan_next;
				if (scan_next == 9'(`LDR_MEMINIT_END)) begin
					scan_run   <= 1'b0;
					inj_done_o <= 1'b1;
				end
			end
		end
	end

	// Write payload, scan writes take the port while running
	always_ff @(posedge clk_sys) begin
		if (scan_run)
			wr_data_o <= '{addr: `LDR_ADDR_W'(scan_addr[7:0]), data: ptr_val};
		else
			wr_data_o <= '{addr: `LDR_ADDR_W'(load_addr), data: dl_byte_i.data};
	end

	// Host sends no new program bytes until the pointer scan is over
	a_no_byte_in_scan: assert property (@(posedge clk_sys) disable iff (!reset_n)
		scan_run |-> !prg_byte);

endmodule

// File: test/tb_clock.sv
// Testbench clock and reset
// 8 ns clock, reset held low for the first 16 cycles

`timescale 1ns/1ns

module tb_clock (
	output logic clk_sys,
	output logic reset_n
);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// Release a little after the edge, like the other stimulus
	initial begin
		reset_n = 1'b0;
		repeat (16) @(posedge clk_sys);
		#1;
		reset_n = 1'b1;
	end

endmodule

// File: test/tb_top.sv
// Loader testbench
// Random PRG and CRT downloads against a reference model of the loader rules

`timescale 1ns/1ns
`include "loader_cfg.svh"

module tb_top import loader_pkg::*; ();

	logic       clk_sys;
	logic       reset_n;
	logic       dl_wr_i;
	logic       dl_active_i;
	dl_byte_t   dl_byte_i;
	logic       mem_slot_i;
	logic       mem_wr_o;
	mem_wr_t    mem_wr_data_o;
	logic       bank_wr_o;
	crt_bank_t  bank_o;
	crt_info_t  crt_info_o;
	logic       cart_attached_o;
	inj_range_t inj_range_o;
	logic       inj_done_o;
	logic       overflow_o;

	int        seed;
	int        inj_done_cnt;
	mem_wr_t   exp_wr_q[$];
	crt_bank_t exp_bank_q[$];

	tb_clock u_clock (
		.clk_sys (clk_sys),
		.reset_n (reset_n)
	);

	c64_loader_top UUT (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_wr_i         (dl_wr_i),
		.dl_active_i     (dl_active_i),
		.dl_byte_i       (dl_byte_i),
		.mem_slot_i      (mem_slot_i),
		.mem_wr_o        (mem_wr_o),
		.mem_wr_data_o   (mem_wr_data_o),
		.bank_wr_o       (bank_wr_o),
		.bank_o          (bank_o),
		.crt_info_o      (crt_info_o),
		.cart_attached_o (cart_attached_o),
		.inj_range_o     (inj_range_o),
		.inj_done_o      (inj_done_o),
		.overflow_o      (overflow_o)
	);

	// ==============================
	// Failure reporting
	// ==============================
	task automatic abort_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string sig, input logic [63:0] got,
	                               input logic [63:0] exp);
		$display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, sig, got, exp);
		abort_run();
	endtask

	task automatic report_failure(input string what);
		$display("At %0t ns: %s", $time, what);
		abort_run();
	endtask

	// ==============================
	// Stimulus helpers
	// ==============================
	function automatic int rand_range(input int lo, input int hi);
		int r;
		r = $random(seed);
		return lo + ((r & 32'h7fffffff) % (hi - lo + 1));
	endfunction

	// One clock; memory slot toggles at random, half the cycles
	task automatic tick();
		@(posedge clk_sys);
		#1;
		mem_slot_i = (rand_range(0, 1) == 1);
	endtask

	// Strobe one byte, then idle so bytes land 3 to 6 cycles apart
	task automatic send_byte(input logic [7:0] idx, input logic [`LDR_ADDR_W-1:0] addr,
	                         input logic [7:0] data);
		int gap;
		gap = rand_range(2, 5);
		dl_byte_i.idx  = idx;
		dl_byte_i.addr = addr;
		dl_byte_i.data = data;
		dl_wr_i = 1'b1;
		tick();
		dl_wr_i = 1'b0;
		repeat (gap) tick();
	endtask

	task automatic expect_write(input logic [`LDR_ADDR_W-1:0] addr, input logic [7:0] data);
		mem_wr_t w;
		w.addr = addr;
		w.data = data;
		exp_wr_q.push_back(w);
	endtask

	// BASIC pointers in scan order, as a LOAD leaves them
	task automatic expect_pointers(input logic [15:0] fin);
		expect_write(`LDR_ADDR_W'('h2b), 8'h01);
		expect_write(`LDR_ADDR_W'('h2c), 8'h08);
		expect_write(`LDR_ADDR_W'('h2d), fin[7:0]);
		expect_write(`LDR_ADDR_W'('h2e), fin[15:8]);
		expect_write(`LDR_ADDR_W'('h2f), fin[7:0]);
		expect_write(`LDR_ADDR_W'('h30), fin[15:8]);
		expect_write(`LDR_ADDR_W'('h31), fin[7:0]);
		expect_write(`LDR_ADDR_W'('h32), fin[15:8]);
		expect_write(`LDR_ADDR_W'('hac), 8'h00);
		expect_write(`LDR_ADDR_W'('had), 8'h00);
		expect_write(`LDR_ADDR_W'('hae), fin[7:0]);
		expect_write(`LDR_ADDR_W'('haf), fin[15:8]);
	endtask

	// Download with foreign file indices, must leave no trace
	task automatic send_other();
		int i;
		dl_active_i = 1'b1;
		tick();
		for (i = 0; i < 8; i++)
			send_byte(8'(rand_range(6, 'hbf)), `LDR_ADDR_W'(i), 8'($random(seed)));
		dl_active_i = 1'b0;
		repeat (4) tick();
	endtask

	task automatic run_prg();
		logic [15:0] start;
		logic [15:0] a;
		logic [7:0]  data;
		int          len;
		int          i;
		int          timeout;
		start = 16'($random(seed));
		len   = rand_range(20, 60);
		dl_active_i = 1'b1;
		tick();
		send_byte(`LDR_IDX_PRG, `LDR_ADDR_W'(0), start[7:0]);
		send_byte(`LDR_IDX_PRG, `LDR_ADDR_W'(1), start[15:8]);
		for (i = 0; i < len; i++) begin
			a    = start + 16'(i);
			data = 8'($random(seed));
			expect_write(`LDR_ADDR_W'(a), data);
			send_byte(`LDR_IDX_PRG, `LDR_ADDR_W'(i + 2), data);
		end
		a = start + 16'(len);
		expect_pointers(a);
		dl_active_i = 1'b0;
		timeout = 0;
		while (inj_done_cnt == 0) begin
			tick();
			timeout++;
			if (timeout > 1000)
				report_failure("timeout waiting for inj_done_o after the PRG download");
		end
		assert (inj_range_o == {start, a})
			else report_mismatch("inj_range_o", inj_range_o, {start, a});
	endtask

	// Cartridge flag drops with the first byte of a CRT download
	task automatic send_crt_byte(input logic [7:0] idx, input int off, input logic [7:0] data);
		if (off != 0) begin
			assert (cart_attached_o == 1'b0)
				else report_mismatch("cart_attached_o", cart_attached_o, 0);
		end
		send_byte(idx, `LDR_ADDR_W'(off), data);
	endtask

	task automatic run_crt();
		logic [7:0]             idx;
		logic [15:0]            hw_id;
		logic [7:0]             exrom;
		logic [7:0]             game;
		logic [7:0]             val;
		logic [7:0]             hdr [16];
		logic [15:0]            plen;
		logic [`LDR_ADDR_W-1:0] base;
		crt_bank_t              bank;
		int                     npkt;
		int                     dlen;
		int                     off;
		int                     p;
		int                     i;
		int                     timeout;
		idx   = (rand_range(0, 1) == 0) ? `LDR_IDX_CRT : `LDR_IDX_CRT_ALT;
		hw_id = 16'($random(seed));
		exrom = 8'($random(seed));
		game  = 8'($random(seed));
		npkt  = rand_range(2, 3);
		dl_active_i = 1'b1;
		tick();
		for (off = 0; off < `LDR_CRT_HDR_LEN; off++) begin
			case (off)
				'h16: val = hw_id[15:8];
				'h17: val = hw_id[7:0];
				'h18: val = exrom;
				'h19: val = game;
				default: val = 8'($random(seed));
			endcase
			send_crt_byte(idx, off, val);
		end
		base = `LDR_CRT_BASE;
		for (p = 0; p < npkt; p++) begin
			dlen = rand_range(1, 24);
			plen = 16'(dlen + `LDR_CRT_PKT_HDR);
			bank.chip_type = 8'(rand_range(0, 2));
			bank.bank_num  = 16'($random(seed));
			bank.load_addr = 16'($random(seed));
			bank.size      = 16'($random(seed));
			exp_bank_q.push_back(bank);
			hdr = '{8'h43, 8'h48, 8'h49, 8'h50, 8'h00, 8'h00, plen[15:8], plen[7:0],
			        8'h00, bank.chip_type, bank.bank_num[15:8], bank.bank_num[7:0],
			        bank.load_addr[15:8], bank.load_addr[7:0], bank.size[15:8],
			        bank.size[7:0]};
			for (i = 0; i < 16; i++) begin
				send_crt_byte(idx, off, hdr[i]);
				off++;
			end
			for (i = 0; i < dlen; i++) begin
				val = 8'($random(seed));
				expect_write(base + `LDR_ADDR_W'(i), val);
				send_crt_byte(idx, off, val);
				off++;
			end
			// Next packet rounds up to an 8 KB boundary
			base = base + `LDR_ADDR_W'(dlen);
			if (base[`LDR_BANK_BITS-1:0] != '0)
				base = (base | `LDR_ADDR_W'((1 << `LDR_BANK_BITS) - 1)) + `LDR_ADDR_W'(1);
		end
		dl_active_i = 1'b0;
		timeout = 0;
		while (!cart_attached_o) begin
			tick();
			timeout++;
			if (timeout > 20)
				report_failure("cart_attached_o did not set after the CRT download");
		end
		assert (crt_info_o == {hw_id, exrom, game})
			else report_mismatch("crt_info_o", crt_info_o, {hw_id, exrom, game});
	endtask

	// ==============================
	// Output monitor
	// ==============================
	always @(negedge clk_sys) begin : monitor
		mem_wr_t   exp_wr;
		crt_bank_t exp_bank;
		if (reset_n) begin
			if (mem_wr_o) begin
				assert (exp_wr_q.size() > 0)
					else report_failure("memory write seen while none was expected");
				exp_wr = exp_wr_q.pop_front();
				assert (mem_wr_data_o == exp_wr)
					else report_mismatch("mem_wr_data_o", mem_wr_data_o, exp_wr);
			end
			if (bank_wr_o) begin
				assert (exp_bank_q.size() > 0)
					else report_failure("bank descriptor seen while none was expected");
				exp_bank = exp_bank_q.pop_front();
				assert (bank_o == exp_bank)
					else report_mismatch("bank_o", bank_o, exp_bank);
			end
			assert (!overflow_o)
				else report_mismatch("overflow_o", overflow_o, 0);
			if (inj_done_o)
				inj_done_cnt++;
		end
	end

	// ==============================
	// Test sequence
	// ==============================
	initial begin : stimulus
		int timeout;
		seed         = 32'hc176;
		inj_done_cnt = 0;
		dl_wr_i      = 1'b0;
		dl_active_i  = 1'b0;
		dl_byte_i    = '0;
		mem_slot_i   = 1'b0;
		timeout = 0;
		while (reset_n !== 1'b1) begin
			tick();
			timeout++;
			if (timeout > 100)
				report_failure("reset was never released");
		end
		send_other();
		run_prg();
		send_other();
		run_crt();
		// A second cartridge starts with the flag still set
		run_crt();
		timeout = 0;
		while (exp_wr_q.size() != 0) begin
			tick();
			timeout++;
			if (timeout > 200)
				report_failure("timeout waiting for the remaining memory writes");
		end
		repeat (4) tick();
		if (exp_bank_q.size() == 0 && inj_done_cnt == 1 && !overflow_o) begin
			$display("Test passed");
			$finish;
		end else begin
			report_failure("descriptors or inj_done_o pulses do not match at end of run");
		end
	end

endmodule
